// ==== src/bus_ctrl_pkg.sv ====
//--------------------------------------------------------------------------
// Settings and readback bus definitions for the board control block.
// Address map, bus widths, compatibility number and the bus structs.
//--------------------------------------------------------------------------
package bus_ctrl_pkg;

   // Bus widths
   localparam int unsigned SET_AWIDTH = 8;
   localparam int unsigned RB_AWIDTH  = 8;
   localparam int unsigned DATA_WIDTH = 32;

   // Settings bus register map
   localparam logic [SET_AWIDTH-1:0] SR_LEDS       = 8'd0;
   localparam logic [SET_AWIDTH-1:0] SR_SW_RST     = 8'd1;
   localparam logic [SET_AWIDTH-1:0] SR_CLOCK_CTRL = 8'd2;
   localparam logic [SET_AWIDTH-1:0] SR_SFPP_CTRL0 = 8'd8;
   localparam logic [SET_AWIDTH-1:0] SR_SFPP_CTRL1 = 8'd9;
   localparam logic [SET_AWIDTH-1:0] SR_FIFOFLAGS  = 8'd10;

   // Readback bus address map
   localparam logic [RB_AWIDTH-1:0] RB_COUNTER      = 8'd0;
   localparam logic [RB_AWIDTH-1:0] RB_CLK_STATUS   = 8'd3;
   localparam logic [RB_AWIDTH-1:0] RB_ETH_TYPE0    = 8'd4;
   localparam logic [RB_AWIDTH-1:0] RB_ETH_TYPE1    = 8'd5;
   localparam logic [RB_AWIDTH-1:0] RB_COMPAT_NUM   = 8'd6;
   localparam logic [RB_AWIDTH-1:0] RB_SFPP_STATUS0 = 8'd8;
   localparam logic [RB_AWIDTH-1:0] RB_SFPP_STATUS1 = 8'd9;
   localparam logic [RB_AWIDTH-1:0] RB_FIFOFLAGS    = 8'd10;

   // Image compatibility, major in the upper half of the word
   localparam logic [15:0] COMPAT_MAJOR = 16'h0008;
   localparam logic [15:0] COMPAT_MINOR = 16'h0000;

   // Ethernet port types, 0 is 1G and 1 is 10G
   localparam logic ETH_TYPE0 = 1'b0;
   localparam logic ETH_TYPE1 = 1'b0;

   // Settings write, 41 bits
   typedef struct packed {
      logic                  stb;
      logic [SET_AWIDTH-1:0] addr;
      logic [DATA_WIDTH-1:0] data;
   } set_bus_t;

   // Readback request, 9 bits
   typedef struct packed {
      logic                 rd_stb;
      logic [RB_AWIDTH-1:0] addr;
   } rb_bus_t;

endpackage

// ==== src/board_io_pkg.sv ====
//--------------------------------------------------------------------------
// Board pin definitions: SFP+ cage pin and status structs, widths of the
// board control outputs and their reset values.
//--------------------------------------------------------------------------
package board_io_pkg;

   // Control and status widths
   localparam int unsigned LED_WIDTH        = 8;
   localparam int unsigned SW_RST_WIDTH     = 4;
   localparam int unsigned CLK_CTRL_WIDTH   = 7;
   localparam int unsigned CLK_STATUS_WIDTH = 5;
   localparam int unsigned FIFO_FLAG_WIDTH  = 4;

   // Bit 6 high selects the GPSDO out of reset
   localparam logic [CLK_CTRL_WIDTH-1:0] CLK_CTRL_RESET = 7'h40;

   // One SFP+ cage's status pins
   typedef struct packed {
      logic mod_abs;
      logic tx_fault;
      logic rx_los;
   } sfpp_pins_t;

   // Readback word bits 5:0, sticky change bits on top
   typedef struct packed {
      sfpp_pins_t chgd;
      sfpp_pins_t level;
   } sfpp_status_t;

   // Rate select drive enables
   // High pulls the open-drain pin low
   typedef struct packed {
      logic rs1;
      logic rs0;
   } sfpp_rs_t;

endpackage

// ==== src/setting_reg.sv ====
//--------------------------------------------------------------------------
// One settings bus register at a fixed address, with a reset value and a
// single-cycle pulse on every write to it.
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module setting_reg
   import bus_ctrl_pkg::*;
#(
   parameter logic [SET_AWIDTH-1:0] ADDR     = '0,
   parameter int unsigned           WIDTH    = 32,
   parameter logic [WIDTH-1:0]      AT_RESET = '0
) (
   input  logic             clk,
   input  logic             reset,
   input  set_bus_t         i_set,
   output logic [WIDTH-1:0] o_value,
   output logic             o_changed
);

   logic hit;

   // Write strobe aimed at this register
   assign hit = i_set.stb && (i_set.addr == ADDR);

   // Register value
   // Low bits of the data word only
   always_ff @(posedge clk) begin
      if (reset) begin
         o_value <= AT_RESET;
      end else if (hit) begin
         o_value <= i_set.data[WIDTH-1:0];
      end
   end

   // Write pulse
   // Lines up with the first cycle of the new value
   always_ff @(posedge clk) begin
      if (reset) begin
         o_changed <= 1'b0;
      end else begin
         o_changed <= hit;
      end
   end

endmodule

// ==== src/sfpp_status_monitor.sv ====
//--------------------------------------------------------------------------
// Status pins of one SFP+ cage: two-flop synchronizer, level readback and
// sticky change bits that clear when their status word is read.
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module sfpp_status_monitor
   import bus_ctrl_pkg::*;
   import board_io_pkg::*;
#(
   parameter logic [RB_AWIDTH-1:0] STATUS_ADDR = '0
) (
   input  logic         clk,
   input  logic         reset,
   input  sfpp_pins_t   i_pins,
   input  rb_bus_t      i_rb,
   output sfpp_status_t o_status
);

   sfpp_pins_t sync1;
   sfpp_pins_t sync2;
   sfpp_pins_t chgd;
   logic [2:0] diff;
   logic       rd_clear;

   // Synchronizer stages
   // Free running, so they settle while reset is held
   always_ff @(posedge clk) begin
      sync1 <= i_pins;
      sync2 <= sync1;
   end

   // New value waiting to enter the second stage
   assign diff = sync1 ^ sync2;

   // Read of our own status word consumes the change bits
   assign rd_clear = i_rb.rd_stb && (i_rb.addr == STATUS_ADDR);

   //-----------------------------------------------------------------------
   // Sticky change bits
   //-----------------------------------------------------------------------
   // Set on the same edge that sync2 takes the new level
   // A clear on that edge wins
   always_ff @(posedge clk) begin
      if (reset) begin
         chgd <= '0;
      end else if (rd_clear) begin
         chgd <= '0;
      end else begin
         chgd <= chgd | diff;
      end
   end

   // Change bits above the level bits
   assign o_status.chgd  = chgd;
   assign o_status.level = sync2;

endmodule

// ==== src/fifo_debug_flags.sv ====
//--------------------------------------------------------------------------
// Sticky capture of FIFO underflow and overflow events. Flags are active
// low at the input and held until a clear strobe.
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module fifo_debug_flags
   import board_io_pkg::*;
(
   input  logic                       clk,
   input  logic                       reset,
   input  logic [FIFO_FLAG_WIDTH-1:0] i_fifo_flags,
   input  logic                       i_clear,
   output logic [FIFO_FLAG_WIDTH-1:0] o_flags
);

   // Low input means an event in that cycle
   // Clear beats a new event
   always_ff @(posedge clk) begin
      if (reset) begin
         o_flags <= '0;
      end else if (i_clear) begin
         o_flags <= '0;
      end else begin
         o_flags <= o_flags | ~i_fifo_flags;
      end
   end

endmodule

// ==== src/readback_mux.sv ====
//--------------------------------------------------------------------------
// Readback side of the control block: free-running cycle counter and the
// address decode that builds the 32-bit readback word.
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module readback_mux
   import bus_ctrl_pkg::*;
   import board_io_pkg::*;
(
   input  logic                        clk,
   input  logic                        reset,
   input  rb_bus_t                     i_rb,
   input  logic [CLK_STATUS_WIDTH-1:0] i_clk_status,
   input  sfpp_status_t                i_sfpp0,
   input  sfpp_status_t                i_sfpp1,
   input  logic [FIFO_FLAG_WIDTH-1:0]  i_fifo_flags,
   output logic [DATA_WIDTH-1:0]       o_rb_data
);

   logic [DATA_WIDTH-1:0] counter;

   //-----------------------------------------------------------------------
   // Cycle counter
   //-----------------------------------------------------------------------
   // Zero in the first cycle after reset release
   always_ff @(posedge clk) begin
      if (reset) begin
         counter <= '0;
      end else begin
         counter <= counter + 1'b1;
      end
   end

   //-----------------------------------------------------------------------
   // Address decode
   //-----------------------------------------------------------------------
   // Narrow fields zero extended to the bus width
   always_comb begin
      case (i_rb.addr)
         RB_COMPAT_NUM: begin
            o_rb_data = {COMPAT_MAJOR, COMPAT_MINOR};
         end
         RB_COUNTER: begin
            o_rb_data = counter;
         end
         RB_CLK_STATUS: begin
            o_rb_data = DATA_WIDTH'(i_clk_status);
         end
         // Configured port types
         RB_ETH_TYPE0: o_rb_data = DATA_WIDTH'(ETH_TYPE0);
         RB_ETH_TYPE1: o_rb_data = DATA_WIDTH'(ETH_TYPE1);
         // SFP+ cages, chgd in 5:3 and level in 2:0
         RB_SFPP_STATUS0: o_rb_data = DATA_WIDTH'(i_sfpp0);
         RB_SFPP_STATUS1: o_rb_data = DATA_WIDTH'(i_sfpp1);
         RB_FIFOFLAGS: begin
            o_rb_data = DATA_WIDTH'(i_fifo_flags);
         end
         // Unmapped
         default: o_rb_data = '0;
      endcase
   end

endmodule

// ==== src/bus_int_ctrl.sv ====
//--------------------------------------------------------------------------
// Board control block top level. Settings bus writes drive the board
// control outputs; the readback bus returns board status and counters.
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module bus_int_ctrl
   import bus_ctrl_pkg::*;
   import board_io_pkg::*;
(
   input  logic                        clk,
   input  logic                        reset,
   input  set_bus_t                    i_set,
   input  rb_bus_t                     i_rb,
   input  logic [CLK_STATUS_WIDTH-1:0] i_clk_status,
   input  logic [FIFO_FLAG_WIDTH-1:0]  i_fifo_flags,
   input  sfpp_pins_t                  i_sfpp0_pins,
   input  sfpp_pins_t                  i_sfpp1_pins,
   output logic [LED_WIDTH-1:0]        o_leds,
   output logic [SW_RST_WIDTH-1:0]     o_sw_rst,
   output logic [CLK_CTRL_WIDTH-1:0]   o_clock_control,
   output sfpp_rs_t                    o_sfpp0_rs,
   output sfpp_rs_t                    o_sfpp1_rs,
   output logic [DATA_WIDTH-1:0]       o_rb_data
);

   sfpp_status_t               sfpp0_status;
   sfpp_status_t               sfpp1_status;
   logic                       clear_flags;
   logic [FIFO_FLAG_WIDTH-1:0] fifo_flags;

   //-----------------------------------------------------------------------
   // Settings registers
   //-----------------------------------------------------------------------
   setting_reg #(.ADDR(SR_LEDS), .WIDTH(LED_WIDTH)) u_set_leds (
      .clk(clk), .reset(reset), .i_set(i_set),
      .o_value(o_leds), .o_changed()
   );

   // Soft resets
   // 0 PHY, 1 radio clock domain, 2 radio clock PLL, 3 spare
   setting_reg #(.ADDR(SR_SW_RST), .WIDTH(SW_RST_WIDTH)) u_set_sw_rst (
      .clk(clk), .reset(reset), .i_set(i_set),
      .o_value(o_sw_rst), .o_changed()
   );

   setting_reg #(
      .ADDR(SR_CLOCK_CTRL), .WIDTH(CLK_CTRL_WIDTH), .AT_RESET(CLK_CTRL_RESET)
   ) u_set_clk_ctrl (
      .clk(clk), .reset(reset), .i_set(i_set),
      .o_value(o_clock_control), .o_changed()
   );

   // RS drive enables, pads sit outside this block
   setting_reg #(.ADDR(SR_SFPP_CTRL0), .WIDTH($bits(sfpp_rs_t))) u_set_sfpp0_ctrl (
      .clk(clk), .reset(reset), .i_set(i_set),
      .o_value(o_sfpp0_rs), .o_changed()
   );

   setting_reg #(.ADDR(SR_SFPP_CTRL1), .WIDTH($bits(sfpp_rs_t))) u_set_sfpp1_ctrl (
      .clk(clk), .reset(reset), .i_set(i_set),
      .o_value(o_sfpp1_rs), .o_changed()
   );

   // Any write here clears the FIFO debug flags
   setting_reg #(.ADDR(SR_FIFOFLAGS), .WIDTH(1)) u_set_flags_clear (
      .clk(clk), .reset(reset), .i_set(i_set),
      .o_value(), .o_changed(clear_flags)
   );

   //-----------------------------------------------------------------------
   // Status capture
   //-----------------------------------------------------------------------
   sfpp_status_monitor #(.STATUS_ADDR(RB_SFPP_STATUS0)) u_sfpp0_mon (
      .clk(clk), .reset(reset), .i_pins(i_sfpp0_pins),
      .i_rb(i_rb), .o_status(sfpp0_status)
   );

   sfpp_status_monitor #(.STATUS_ADDR(RB_SFPP_STATUS1)) u_sfpp1_mon (
      .clk(clk), .reset(reset), .i_pins(i_sfpp1_pins),
      .i_rb(i_rb), .o_status(sfpp1_status)
   );

   fifo_debug_flags u_fifo_flags (
      .clk(clk), .reset(reset), .i_fifo_flags(i_fifo_flags),
      .i_clear(clear_flags), .o_flags(fifo_flags)
   );

   // Readback word and cycle counter
   readback_mux u_readback (
      .clk(clk),
      .reset(reset),
      .i_rb(i_rb),
      .i_clk_status(i_clk_status),
      .i_sfpp0(sfpp0_status),
      .i_sfpp1(sfpp1_status),
      .i_fifo_flags(fifo_flags),
      .o_rb_data(o_rb_data)
   );

endmodule

// ==== tests/bus_int_ctrl_sva.sv ====
//--------------------------------------------------------------------------
// Concurrent checks bound into the control block top level: clock control
// reset value, SFP+ change bit rules and sticky FIFO flag rules.
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module bus_int_ctrl_sva
   import board_io_pkg::*;
(
   input logic                       clk,
   input logic                       reset,
   input logic [CLK_CTRL_WIDTH-1:0]  o_clock_control,
   input sfpp_status_t               sfpp0_status,
   input sfpp_status_t               sfpp1_status,
   input logic [FIFO_FLAG_WIDTH-1:0] fifo_flags,
   input logic                       clear_flags
);

   // Clock control back to GPSDO on after a reset cycle
   a_clk_ctrl_reset : assert property (@(posedge clk)
      reset |=> (o_clock_control == CLK_CTRL_RESET))
      else $error("clock control not at reset value after reset");

   // A rising change bit needs a level change on the same edge
   a_sfpp0_chgd : assert property (@(posedge clk) disable iff (reset)
      ((sfpp0_status.chgd & ~$past(sfpp0_status.chgd))
         & ~(sfpp0_status.level ^ $past(sfpp0_status.level))) == 3'b000)
      else $error("cage 0 change bit rose without a level change");

   a_sfpp1_chgd : assert property (@(posedge clk) disable iff (reset)
      ((sfpp1_status.chgd & ~$past(sfpp1_status.chgd))
         & ~(sfpp1_status.level ^ $past(sfpp1_status.level))) == 3'b000)
      else $error("cage 1 change bit rose without a level change");

   // Sticky flags only fall on the edge after a clear pulse
   a_flags_sticky : assert property (@(posedge clk) disable iff (reset)
      (($past(fifo_flags) & ~fifo_flags) != '0) |-> $past(clear_flags))
      else $error("FIFO flag fell without a clear write");

endmodule

// ==== tests/bus_int_ctrl_tb.sv ====
//--------------------------------------------------------------------------
// Table driven testbench for the board control block. Applies a table of
// settings writes, readbacks, pin changes and FIFO events to the top level.
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module tb_bus_int_ctrl
   import bus_ctrl_pkg::*;
   import board_io_pkg::*;
;

   // Step kinds
   localparam logic [2:0] K_IDLE = 3'd0;
   localparam logic [2:0] K_WRITE = 3'd1;
   localparam logic [2:0] K_WRITE_RND = 3'd2;
   localparam logic [2:0] K_READ = 3'd3;
   localparam logic [2:0] K_COUNT = 3'd4;
   localparam logic [2:0] K_PINS = 3'd5;

   typedef struct packed {
      logic [2:0]                 kind;
      logic [7:0]                 addr;
      logic [31:0]                data;
      sfpp_pins_t                 pins;
      logic [FIFO_FLAG_WIDTH-1:0] flags;
      logic [31:0]                expected;
   } step_t;

   logic                        clk;
   logic                        reset;
   set_bus_t                    i_set;
   rb_bus_t                     i_rb;
   logic [CLK_STATUS_WIDTH-1:0] i_clk_status;
   logic [FIFO_FLAG_WIDTH-1:0]  i_fifo_flags;
   sfpp_pins_t                  i_sfpp0_pins;
   sfpp_pins_t                  i_sfpp1_pins;
   logic [LED_WIDTH-1:0]        o_leds;
   logic [SW_RST_WIDTH-1:0]     o_sw_rst;
   logic [CLK_CTRL_WIDTH-1:0]   o_clock_control;
   sfpp_rs_t                    o_sfpp0_rs;
   sfpp_rs_t                    o_sfpp1_rs;
   logic [DATA_WIDTH-1:0]       o_rb_data;

   step_t  steps[$];
   integer seed = 20066;
   int     ticks = 0;
   int     limit = 100000;
   int     since_release = 0;

   // Expected control outputs
   logic [7:0] m_leds;
   logic [3:0] m_sw_rst;
   logic [6:0] m_clk;
   logic [1:0] m_rs0;
   logic [1:0] m_rs1;

   bus_int_ctrl u_bus_int_ctrl (.*);

   bind bus_int_ctrl bus_int_ctrl_sva u_sva (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Cycle counts and the run limit
   always @(posedge clk) begin
      ticks <= ticks + 1;
      if (!reset) begin
         since_release <= since_release + 1;
      end
      if (ticks > limit) begin
         $display("[FAIL] run did not finish within %0d cycles", limit);
         $display("sim failed");
         $fatal(1, "timeout");
      end
   end

   //-----------------------------------------------------------------------
   // Compare tasks
   //-----------------------------------------------------------------------
   task automatic stop_on_error(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      $display("sim failed");
      $fatal(1, "mismatch");
   endtask

   task automatic check_word(input string name, input logic [DATA_WIDTH-1:0] got,
                             input logic [DATA_WIDTH-1:0] exp);
      if (got !== exp) stop_on_error(name, got, exp);
   endtask

   task automatic check_status(input string name, input sfpp_status_t got,
                               input sfpp_status_t exp);
      if (got !== exp) stop_on_error(name, 32'(got), 32'(exp));
   endtask

   // Narrow controls arrive zero extended to the LED width
   task automatic check_ctrl(input string name, input logic [LED_WIDTH-1:0] got,
                             input logic [LED_WIDTH-1:0] exp);
      if (got !== exp) stop_on_error(name, 32'(got), 32'(exp));
   endtask

   task automatic check_all_ctrl();
      check_ctrl("o_leds", o_leds, m_leds);
      check_ctrl("o_sw_rst", 8'(o_sw_rst), 8'(m_sw_rst));
      check_ctrl("o_clock_control", 8'(o_clock_control), 8'(m_clk));
      check_ctrl("o_sfpp0_rs", 8'(o_sfpp0_rs), 8'(m_rs0));
      check_ctrl("o_sfpp1_rs", 8'(o_sfpp1_rs), 8'(m_rs1));
   endtask

   //-----------------------------------------------------------------------
   // Stimulus table
   //-----------------------------------------------------------------------
   task automatic add(input logic [2:0] kind, input logic [7:0] addr,
                      input logic [31:0] data, input sfpp_pins_t pins,
                      input logic [3:0] flags, input logic [31:0] expected);
      steps.push_back(step_t'{kind, addr, data, pins, flags, expected});
   endtask

   task automatic build_table();
      // Reset values and constants
      add(K_READ, 8'd6, 0, 3'b000, 4'hF, 32'h0008_0000);
      add(K_READ, 8'd4, 0, 3'b000, 4'hF, 32'(ETH_TYPE0));
      add(K_READ, 8'd5, 0, 3'b000, 4'hF, 32'(ETH_TYPE1));
      // Writes masked to each width
      add(K_WRITE, 8'd0, 32'h1234_56A5, 3'b000, 4'hF, 0);
      add(K_WRITE, 8'd2, 32'hFFFF_FFFF, 3'b000, 4'hF, 0);
      add(K_WRITE_RND, 8'd0, 0, 3'b000, 4'hF, 0);
      add(K_WRITE_RND, 8'd1, 0, 3'b000, 4'hF, 0);
      add(K_WRITE_RND, 8'd2, 0, 3'b000, 4'hF, 0);
      add(K_WRITE_RND, 8'd8, 0, 3'b000, 4'hF, 0);
      add(K_WRITE_RND, 8'd9, 0, 3'b000, 4'hF, 0);
      add(K_WRITE_RND, 8'd3, 0, 3'b000, 4'hF, 0);
      add(K_WRITE_RND, 8'd77, 0, 3'b000, 4'hF, 0);
      add(K_COUNT, 8'd0, 0, 3'b000, 4'hF, 0);
      // Cage 0 change and a read that clears chgd only
      add(K_PINS, 8'd0, 0, 3'b101, 4'hF, 0);
      add(K_IDLE, 8'd0, 0, 3'b000, 4'hF, 0);
      add(K_READ, 8'd8, 1, 3'b000, 4'hF, 32'h0000_002D);
      add(K_READ, 8'd8, 0, 3'b000, 4'hF, 32'h0000_0005);
      add(K_READ, 8'd9, 0, 3'b000, 4'hF, 32'h0000_0000);
      // Cage 1 change
      add(K_PINS, 8'd1, 0, 3'b010, 4'hF, 0);
      add(K_IDLE, 8'd0, 0, 3'b000, 4'hF, 0);
      add(K_READ, 8'd9, 0, 3'b000, 4'hF, 32'h0000_0012);
      add(K_READ, 8'd9, 1, 3'b000, 4'hF, 32'h0000_0012);
      add(K_READ, 8'd9, 0, 3'b000, 4'hF, 32'h0000_0002);
      add(K_READ, 8'd8, 0, 3'b000, 4'hF, 32'h0000_0005);
      // FIFO events on bits 0 and 3 followed by a clear
      add(K_IDLE, 8'd0, 0, 3'b000, 4'hE, 0);
      add(K_IDLE, 8'd0, 0, 3'b000, 4'hF, 0);
      add(K_READ, 8'd10, 0, 3'b000, 4'hF, 32'h0000_0001);
      add(K_IDLE, 8'd0, 0, 3'b000, 4'h7, 0);
      add(K_READ, 8'd10, 0, 3'b000, 4'hF, 32'h0000_0009);
      add(K_WRITE, 8'd10, 32'h0000_0000, 3'b000, 4'hF, 0);
      add(K_READ, 8'd10, 0, 3'b000, 4'hF, 32'h0000_0000);
      // Clock status and unmapped reads
      add(K_READ, 8'd3, 0, 3'b000, 4'hF, 32'h0000_0015);
      add(K_READ, 8'd1, 0, 3'b000, 4'hF, 32'h0000_0000);
      add(K_READ, 8'd7, 0, 3'b000, 4'hF, 32'h0000_0000);
      add(K_READ, 8'd11, 0, 3'b000, 4'hF, 32'h0000_0000);
      add(K_READ, 8'hFF, 0, 3'b000, 4'hF, 32'h0000_0000);
      add(K_COUNT, 8'd0, 0, 3'b000, 4'hF, 0);
   endtask

   // Expected register update from the address map
   task automatic model_write(input logic [7:0] addr, input logic [31:0] data);
      case (addr)
         8'd0: m_leds = data[7:0];
         8'd1: m_sw_rst = data[3:0];
         8'd2: m_clk = data[6:0];
         8'd8: m_rs0 = data[1:0];
         8'd9: m_rs1 = data[1:0];
         default: ;
      endcase
   endtask

   //-----------------------------------------------------------------------
   // Main sequence
   //-----------------------------------------------------------------------
   initial begin
      step_t       s;
      logic [31:0] wdata;
      reset = 1'b1;
      i_set = '0;
      i_rb = '0;
      i_clk_status = 5'h15;
      i_fifo_flags = 4'hF;
      i_sfpp0_pins = 3'b000;
      i_sfpp1_pins = 3'b000;
      m_leds = 8'h00;
      m_sw_rst = 4'h0;
      m_clk = 7'h40;
      m_rs0 = 2'b00;
      m_rs1 = 2'b00;
      build_table();
      limit = 4 * steps.size() + 50;
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      #1;
      check_all_ctrl();
      foreach (steps[i]) begin
         s = steps[i];
         @(negedge clk);
         i_set = '0;
         i_rb = '0;
         i_fifo_flags = s.flags;
         case (s.kind)
            K_WRITE, K_WRITE_RND: begin
               wdata = (s.kind == K_WRITE) ? s.data : $random(seed);
               i_set = '{stb: 1'b1, addr: s.addr, data: wdata};
               model_write(s.addr, wdata);
               // New value one cycle after the strobe
               @(negedge clk);
               i_set = '0;
               check_all_ctrl();
            end
            K_READ: begin
               i_rb = '{rd_stb: s.data[0], addr: s.addr};
               #1;
               if (s.addr == 8'd8 || s.addr == 8'd9) begin
                  check_status("sfpp status", o_rb_data[5:0], s.expected[5:0]);
               end
               check_word("o_rb_data", o_rb_data, s.expected);
            end
            K_COUNT: begin
               i_rb = '{rd_stb: 1'b0, addr: RB_COUNTER};
               #1;
               check_word("cycle counter", o_rb_data, 32'(since_release));
            end
            K_PINS: begin
               if (s.addr[0]) begin
                  i_sfpp1_pins = s.pins;
               end else begin
                  i_sfpp0_pins = s.pins;
               end
            end
            default: ;
         endcase
      end
      @(negedge clk);
      $display("sim passed");
      $finish;
   end

endmodule

// ==== bus_int_ctrl.f ====
src/bus_ctrl_pkg.sv
src/board_io_pkg.sv
src/setting_reg.sv
src/sfpp_status_monitor.sv
src/fifo_debug_flags.sv
src/readback_mux.sv
src/bus_int_ctrl.sv
tests/bus_int_ctrl_sva.sv
tests/bus_int_ctrl_tb.sv

// ==== Makefile ====
# Verilator build and run for the board control block testbench

VERILATOR ?= verilator
TOP       ?= tb_bus_int_ctrl
FLIST     ?= bus_int_ctrl.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -Wno-fatal

SRCS := $(wildcard src/*.sv tests/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^sim passed$$" $(LOG) || (echo "testbench reported failure" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
